// File: hdl/rv_core_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I integer core package
// Widths, major opcodes, funct fields, ALU operations and the
// structs that travel between decode, execute and retire
//////////////////////////////////////////////////////////////////////

package rv_core_pkg;

  // Data path sizes
  parameter int unsigned XLEN     = 32;
  parameter int unsigned NUM_REGS = 32;

  typedef logic [31:0]      instr_t;
  typedef logic [4:0]       rf_addr_t;
  typedef logic [XLEN-1:0]  rf_data_t;

  // Major opcodes kept in this core
  parameter logic [6:0] OPCODE_OP     = 7'h33;
  parameter logic [6:0] OPCODE_OP_IMM = 7'h13;
  parameter logic [6:0] OPCODE_LUI    = 7'h37;

  // funct3 encodings shared by OP and OP-IMM
  parameter logic [2:0] F3_ADD  = 3'b000;
  parameter logic [2:0] F3_SLL  = 3'b001;
  parameter logic [2:0] F3_SLT  = 3'b010;
  parameter logic [2:0] F3_SLTU = 3'b011;
  parameter logic [2:0] F3_XOR  = 3'b100;
  parameter logic [2:0] F3_SR   = 3'b101;
  parameter logic [2:0] F3_OR   = 3'b110;
  parameter logic [2:0] F3_AND  = 3'b111;

  // funct7 values, ALT selects SUB and SRA
  parameter logic [6:0] F7_BASE = 7'b000_0000;
  parameter logic [6:0] F7_ALT  = 7'b010_0000;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Decode to execute
  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    rf_data_t operand_a;
    rf_data_t operand_b;
    rf_addr_t rd;
    logic     rf_we;
    logic     illegal;
  } id_ex_pipe_t;

  // Execute to retire
  typedef struct packed {
    logic     valid;
    rf_addr_t rd;
    logic     rf_we;
    logic     illegal;
    rf_data_t result;
  } ex_wb_pipe_t;

  // Record on the retire port
  typedef struct packed {
    rf_addr_t rd;
    rf_data_t result;
    logic     rf_we;
    logic     illegal;
  } retire_rec_t;

endpackage

// File: hdl/rv_credit_fifo.sv
//////////////////////////////////////////////////////////////////////
// Credit FIFO
// Circular buffer for any payload type, returns one credit to the
// upstream source for every entry that leaves
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_credit_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output logic     head_valid_o,
  output payload_t head_data_o,
  output logic     credit_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // Pop only counts when something sits at the head
  assign do_pop       = pop_i && head_valid_o;
  assign head_valid_o = (count != '0);
  assign head_data_o  = mem[rd_ptr];
  // One credit back per freed entry
  assign credit_o     = do_pop;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Credit rule keeps count within DEPTH
      case ({push_i, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/rv_register_file.sv
//////////////////////////////////////////////////////////////////////
// Register file
// 32 x XLEN, two combinational read ports, one write port,
// x0 reads as zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_register_file import rv_core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  rf_addr_t raddr_a_i,
  input  rf_addr_t raddr_b_i,
  output rf_data_t rdata_a_o,
  output rf_data_t rdata_b_o,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  rf_data_t wdata_i
);

  rf_data_t regs [NUM_REGS];

  // Write port, x0 writes dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Read ports
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: hdl/rv_decode_stage.sv
//////////////////////////////////////////////////////////////////////
// Decode stage
// Decodes OP, OP-IMM and LUI, flags illegal encodings, reads and
// forwards source operands and holds the ID/EX pipeline register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_decode_stage import rv_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        instr_valid_i,
  input  instr_t      instr_i,
  output logic        instr_pop_o,
  input  logic        ex_ready_i,
  input  rf_data_t    ex_fwd_data_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  output rf_addr_t    rf_raddr_a_o,
  output rf_addr_t    rf_raddr_b_o,
  input  rf_data_t    rf_rdata_a_i,
  input  rf_data_t    rf_rdata_b_i,
  output id_ex_pipe_t id_ex_pipe_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  rf_addr_t    rs1;
  rf_addr_t    rs2;
  rf_data_t    imm_i;
  rf_data_t    imm_u;
  rf_data_t    rs1_data;
  rf_data_t    rs2_data;
  alu_op_e     alu_op;
  logic        illegal;
  logic        use_imm;
  logic        is_lui;
  id_ex_pipe_t id_ex_q;

  // Instruction fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign imm_i  = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u  = {instr_i[31:12], 12'b0};

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    alu_op  = ALU_ADD;
    illegal = 1'b0;
    use_imm = 1'b0;
    is_lui  = 1'b0;
    case (opcode)
      OPCODE_OP, OPCODE_OP_IMM: begin
        use_imm = (opcode == OPCODE_OP_IMM);
        case (funct3)
          F3_ADD:  alu_op = (!use_imm && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:  alu_op = ALU_SLL;
          F3_SLT:  alu_op = ALU_SLT;
          F3_SLTU: alu_op = ALU_SLTU;
          F3_XOR:  alu_op = ALU_XOR;
          F3_SR:   alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:   alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
        // funct7 checks, immediates only constrain the shifts
        if (!use_imm || funct3 == F3_SLL || funct3 == F3_SR) begin
          if (funct7 != F7_BASE && !(funct7 == F7_ALT &&
              (funct3 == F3_SR || (!use_imm && funct3 == F3_ADD)))) begin
            illegal = 1'b1;
          end
        end
      end
      OPCODE_LUI: begin
        is_lui = 1'b1;
        alu_op = ALU_PASS_B;
      end
      default: illegal = 1'b1;
    endcase
  end

  // Youngest producer wins, EX ahead of WB, x0 never forwarded
  function automatic rf_data_t fwd_operand(rf_addr_t addr, rf_data_t rf_val);
    rf_data_t val;
    val = rf_val;
    if (ex_wb_pipe_i.valid && ex_wb_pipe_i.rf_we && ex_wb_pipe_i.rd == addr && addr != '0) begin
      val = ex_wb_pipe_i.result;
    end
    if (id_ex_q.valid && id_ex_q.rf_we && id_ex_q.rd == addr && addr != '0) begin
      val = ex_fwd_data_i;
    end
    return val;
  endfunction

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  // Operand select follows both pipe registers and the ALU
  always_comb begin
    rs1_data = fwd_operand(rs1, rf_rdata_a_i);
    rs2_data = fwd_operand(rs2, rf_rdata_b_i);
  end

  // Leaves the FIFO only when ID/EX takes it
  assign instr_pop_o = instr_valid_i && ex_ready_i;

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_ex_q <= '0;
    end else if (ex_ready_i) begin
      id_ex_q.valid     <= instr_valid_i;
      id_ex_q.alu_op    <= alu_op;
      // Illegal ones carry zero operands and so retire a zero result
      id_ex_q.operand_a <= (illegal || is_lui) ? '0 : rs1_data;
      id_ex_q.operand_b <= illegal ? '0 : is_lui ? imm_u : use_imm ? imm_i : rs2_data;
      id_ex_q.rd        <= instr_i[11:7];
      id_ex_q.rf_we     <= !illegal;
      id_ex_q.illegal   <= illegal;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

endmodule

// File: hdl/rv_execute_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute stage
// ALU for the RV32I integer operations and the EX/WB pipeline
// register, ALU result also forwarded back into decode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_execute_stage import rv_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  input  logic        wb_ready_i,
  output logic        ex_ready_o,
  output rf_data_t    ex_fwd_data_o,
  output ex_wb_pipe_t ex_wb_pipe_o
);

  rf_data_t    op_a;
  rf_data_t    op_b;
  logic [4:0]  shamt;
  rf_data_t    alu_result;
  ex_wb_pipe_t ex_wb_q;

  assign op_a  = id_ex_pipe_i.operand_a;
  assign op_b  = id_ex_pipe_i.operand_b;
  // Shift amount from low 5 bits only
  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (id_ex_pipe_i.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = rf_data_t'($signed(op_a) >>> shamt);
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      // LUI
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // Forward path into decode
  assign ex_fwd_data_o = alu_result;

  // Free when empty or when the item moves to EX/WB this cycle
  assign ex_ready_o = !id_ex_pipe_i.valid || wb_ready_i;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_wb_q <= '0;
    end else if (wb_ready_i) begin
      ex_wb_q.valid   <= id_ex_pipe_i.valid;
      ex_wb_q.rd      <= id_ex_pipe_i.rd;
      ex_wb_q.rf_we   <= id_ex_pipe_i.rf_we;
      ex_wb_q.illegal <= id_ex_pipe_i.illegal;
      ex_wb_q.result  <= alu_result;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

// File: hdl/rv_retire_unit.sv
//////////////////////////////////////////////////////////////////////
// Retire unit
// Tracks retire credits, sends one record per credit from EX/WB and
// writes the register file in the same cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_retire_unit import rv_core_pkg::*; #(
  parameter int unsigned RETIRE_CREDITS = 2
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  input  logic        retire_credit_i,
  output logic        wb_ready_o,
  output logic        retire_valid_o,
  output retire_rec_t retire_rec_o,
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output rf_data_t    rf_wdata_o
);

  localparam int unsigned CNT_W = $clog2(RETIRE_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;
  logic             have_credit;
  logic             send;

  assign have_credit = (credit_cnt != '0);
  assign send        = ex_wb_pipe_i.valid && have_credit;

  // EX/WB frees up when empty or when its record goes out
  assign wb_ready_o = !ex_wb_pipe_i.valid || have_credit;

  // Retire port
  assign retire_valid_o       = send;
  assign retire_rec_o.rd      = ex_wb_pipe_i.rd;
  assign retire_rec_o.result  = ex_wb_pipe_i.result;
  assign retire_rec_o.rf_we   = ex_wb_pipe_i.rf_we;
  assign retire_rec_o.illegal = ex_wb_pipe_i.illegal;

  // Architectural write lines up with the record
  assign rf_we_o    = send && ex_wb_pipe_i.rf_we;
  assign rf_waddr_o = ex_wb_pipe_i.rd;
  assign rf_wdata_o = ex_wb_pipe_i.result;

  //////////////////////////////////////////////////////////////////////
  // Credit counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt <= CNT_W'(RETIRE_CREDITS);
    end else begin
      // Return and spend in one cycle cancel out
      case ({retire_credit_i, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// File: hdl/rv_core_top.sv
//////////////////////////////////////////////////////////////////////
// RV32I integer core top level
// Credit issue FIFO, decode, execute, retire and register file
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; #(
  parameter int unsigned ISSUE_DEPTH    = 4,
  parameter int unsigned RETIRE_CREDITS = 2
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Issue port
  input  logic        issue_valid_i,
  input  instr_t      issue_instr_i,
  output logic        issue_credit_o,
  // Retire port
  input  logic        retire_credit_i,
  output logic        retire_valid_o,
  output retire_rec_t retire_rec_o
);

  // FIFO head into decode
  logic        fifo_valid;
  instr_t      fifo_instr;
  logic        fifo_pop;
  // Stage handshakes and pipes
  logic        ex_ready;
  logic        wb_ready;
  rf_data_t    ex_fwd_data;
  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;
  // Register file ports
  rf_addr_t    rf_raddr_a;
  rf_addr_t    rf_raddr_b;
  rf_data_t    rf_rdata_a;
  rf_data_t    rf_rdata_b;
  logic        rf_we;
  rf_addr_t    rf_waddr;
  rf_data_t    rf_wdata;

  //////////////////////////////////////////////////////////////////////
  // Issue side
  //////////////////////////////////////////////////////////////////////
  rv_credit_fifo #(
    .DEPTH     (ISSUE_DEPTH),
    .payload_t (instr_t)
  ) issue_fifo_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (issue_valid_i),
    .push_data_i  (issue_instr_i),
    .pop_i        (fifo_pop),
    .head_valid_o (fifo_valid),
    .head_data_o  (fifo_instr),
    .credit_o     (issue_credit_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////////////////////////
  rv_decode_stage decode_stage_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (fifo_valid),
    .instr_i       (fifo_instr),
    .instr_pop_o   (fifo_pop),
    .ex_ready_i    (ex_ready),
    .ex_fwd_data_i (ex_fwd_data),
    .ex_wb_pipe_i  (ex_wb_pipe),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  rv_register_file register_file_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  rv_execute_stage execute_stage_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .id_ex_pipe_i  (id_ex_pipe),
    .wb_ready_i    (wb_ready),
    .ex_ready_o    (ex_ready),
    .ex_fwd_data_o (ex_fwd_data),
    .ex_wb_pipe_o  (ex_wb_pipe)
  );

  //////////////////////////////////////////////////////////////////////
  // Retire side
  //////////////////////////////////////////////////////////////////////
  rv_retire_unit #(
    .RETIRE_CREDITS (RETIRE_CREDITS)
  ) retire_unit_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .ex_wb_pipe_i    (ex_wb_pipe),
    .retire_credit_i (retire_credit_i),
    .wb_ready_o      (wb_ready),
    .retire_valid_o  (retire_valid_o),
    .retire_rec_o    (retire_rec_o),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata)
  );

endmodule

// File: verification/rv_core_props.sv
//////////////////////////////////////////////////////////////////////
// Retire credit properties
// Concurrent checks on the retire unit credit counter and the
// retire valid strobe, bound into every rv_retire_unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_core_props #(
  parameter int unsigned RETIRE_CREDITS = 2
) (
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input logic [$clog2(RETIRE_CREDITS + 1)-1:0] credit_cnt_i,
  input logic                                  retire_credit_i,
  input logic                                  retire_valid_i
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // Pipeline registers clear on the first reset edge
  logic in_reset_q = 1'b0;

  // Credits granted by the sink and not yet spent, seen from the ports
  int unsigned avail_q = 0;

  always @(posedge clk_i) begin
    in_reset_q <= !rst_n_i;
    if (!rst_n_i) begin
      avail_q <= RETIRE_CREDITS;
    end else begin
      avail_q <= avail_q + retire_credit_i - retire_valid_i;
    end
  end

  // Counter bounded by the initial credit grant
  credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_i <= RETIRE_CREDITS)
    else begin
      fail_count++;
      $error("Retire credit count above its initial grant");
    end

  // A record always spends a credit the sink granted
  valid_needs_credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    retire_valid_i |-> avail_q != 0)
    else begin
      fail_count++;
      $error("Retire record sent with no credit held");
    end

  // Quiet retire port while reset is held
  quiet_in_reset_a: assert property (@(posedge clk_i)
    (!rst_n_i && in_reset_q) |-> !retire_valid_i)
    else begin
      fail_count++;
      $error("Retire valid high during reset");
    end

endmodule

bind rv_retire_unit rv_core_props #(
  .RETIRE_CREDITS (RETIRE_CREDITS)
) props_i (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .credit_cnt_i    (credit_cnt),
  .retire_credit_i (retire_credit_i),
  .retire_valid_i  (retire_valid_o)
);

// File: verification/tb_rv_core.sv
//////////////////////////////////////////////////////////////////////
// RV32I core testbench
// Random OP, OP-IMM and LUI stream through the credit issue port,
// architectural model, random retire credit returns and checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*; ();

  localparam int unsigned ISSUE_DEPTH    = 4;
  localparam int unsigned RETIRE_CREDITS = 2;
  localparam int unsigned NUM_INSTR      = 300;
  localparam int unsigned TIMEOUT_CYCLES = NUM_INSTR * 20;
  localparam logic [31:0] SEED           = 32'h0ee1_8309;

  logic        clk_i;
  logic        rst_n_i;
  logic        issue_valid_i;
  instr_t      issue_instr_i;
  logic        issue_credit_o;
  logic        retire_credit_i;
  logic        retire_valid_o;
  retire_rec_t retire_rec_o;

  // Model state and bookkeeping
  rf_data_t    model_regs [NUM_REGS];
  rf_addr_t    recent_rd [4];
  int unsigned recent_idx;
  retire_rec_t exp_q [$];
  int unsigned issued;
  int unsigned retired;
  int unsigned returned;
  int unsigned owed;
  int unsigned hold_cycles;
  int unsigned issue_credits;
  int unsigned credit_pulses;
  int unsigned checks_run;
  int unsigned error_count;
  int unsigned cycle_count;

  rv_core_top #(
    .ISSUE_DEPTH    (ISSUE_DEPTH),
    .RETIRE_CREDITS (RETIRE_CREDITS)
  ) DUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .issue_valid_i   (issue_valid_i),
    .issue_instr_i   (issue_instr_i),
    .issue_credit_o  (issue_credit_o),
    .retire_credit_i (retire_credit_i),
    .retire_valid_o  (retire_valid_o),
    .retire_rec_o    (retire_rec_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks_run++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
               $time, name, actual, expected);
    end
  endtask

  task automatic print_summary();
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d, retired: %0d",
             checks_run, error_count, DUT.retire_unit_i.props_i.fail_count, retired);
  endtask

  // RV32I integer semantics by funct3, alt selects SUB and SRA
  function automatic rf_data_t alu_model(logic [2:0] f3, logic alt, rf_data_t a,
                                         rf_data_t b);
    logic signed [31:0] sa;
    logic [4:0]         sh;
    rf_data_t           res;
    sa = a;
    sh = b[4:0];
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << sh;
      3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: res = (a < b) ? 32'd1 : 32'd0;
      3'd4: res = a ^ b;
      3'd5: begin
        if (alt) res = sa >>> sh;
        else res = a >> sh;
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // About 40% of sources reuse a recent destination
  function automatic rf_addr_t pick_source();
    if ($urandom_range(0, 99) < 40) begin
      return recent_rd[$urandom_range(0, 3)];
    end
    return rf_addr_t'($urandom_range(0, 31));
  endfunction

  // Random encoding, executed on the model at issue time
  task automatic generate_instr(output instr_t instr);
    int unsigned kind;
    rf_addr_t    rd;
    rf_addr_t    rs1;
    rf_addr_t    rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  opc;
    logic [11:0] imm12;
    logic [31:0] bits;
    retire_rec_t rec;
    kind = $urandom_range(0, 99);
    rd   = rf_addr_t'($urandom_range(0, 31));
    rs1  = pick_source();
    rs2  = pick_source();
    f3   = 3'($urandom_range(0, 7));
    bits = $urandom();
    rec.rd      = rd;
    rec.rf_we   = 1'b1;
    rec.illegal = 1'b0;
    if (kind < 5) begin
      // Unknown major opcode
      do begin
        opc = 7'($urandom_range(0, 127));
      end while (opc == OPCODE_OP || opc == OPCODE_OP_IMM || opc == OPCODE_LUI);
      instr       = {bits[31:12], rd, opc};
      rec.result  = '0;
      rec.rf_we   = 1'b0;
      rec.illegal = 1'b1;
    end else if (kind < 40) begin
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && bits[0]) ? 7'h20 : 7'h00;
      instr      = {f7, rs2, rs1, f3, rd, OPCODE_OP};
      rec.result = alu_model(f3, f7[5], model_regs[rs1], model_regs[rs2]);
    end else if (kind < 75) begin
      imm12 = bits[11:0];
      // Shift immediates constrain the upper seven bits
      if (f3 == 3'd1) imm12[11:5] = 7'h00;
      if (f3 == 3'd5) imm12[11:5] = bits[12] ? 7'h20 : 7'h00;
      instr      = {imm12, rs1, f3, rd, OPCODE_OP_IMM};
      rec.result = alu_model(f3, (f3 == 3'd5) && imm12[10], model_regs[rs1],
                             {{20{imm12[11]}}, imm12});
    end else begin
      instr      = {bits[31:12], rd, OPCODE_LUI};
      rec.result = {bits[31:12], 12'h000};
    end
    // x0 stays zero
    if (rec.rf_we && rd != '0) model_regs[rd] = rec.result;
    recent_rd[recent_idx] = rd;
    recent_idx = (recent_idx + 1) % 4;
    exp_q.push_back(rec);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions retired",
               cycle_count, retired, NUM_INSTR);
      print_summary();
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  //////////////////////////////////////////////////////////////////////
  initial begin
    instr_t      instr;
    retire_rec_t exp;
    void'($urandom(SEED));
    rst_n_i         = 1'b0;
    issue_valid_i   = 1'b0;
    issue_instr_i   = '0;
    retire_credit_i = 1'b0;
    model_regs      = '{default: '0};
    recent_rd       = '{default: '0};
    recent_idx      = 0;
    issued          = 0;
    retired         = 0;
    returned        = 0;
    owed            = 0;
    hold_cycles     = 0;
    issue_credits   = ISSUE_DEPTH;
    credit_pulses   = 0;
    checks_run      = 0;
    error_count     = 0;
    cycle_count     = 0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Idle after reset
    repeat (6) begin
      @(posedge clk_i);
      check_value("retire_valid_o", retire_valid_o, 1'b0);
      check_value("issue_credit_o", issue_credit_o, 1'b0);
    end

    while (retired < NUM_INSTR) begin
      @(posedge clk_i);
      if (issue_credit_o) begin
        credit_pulses++;
        issue_credits++;
        if (issue_credits > ISSUE_DEPTH) begin
          error_count++;
          $display("Issue credit returned with no instruction outstanding at %0t", $time);
        end
      end
      if (retire_valid_o) begin
        retired++;
        owed++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Retire record at %0t with no instruction expected", $time);
        end else begin
          exp = exp_q.pop_front();
          check_value("retire_rec_o.rd", retire_rec_o.rd, exp.rd);
          check_value("retire_rec_o.result", retire_rec_o.result, exp.result);
          check_value("retire_rec_o.rf_we", retire_rec_o.rf_we, exp.rf_we);
          check_value("retire_rec_o.illegal", retire_rec_o.illegal, exp.illegal);
        end
        // Outstanding records bounded by returned credits
        if (retired > returned + RETIRE_CREDITS) begin
          error_count++;
          $display("Retire record at %0t sent beyond the credits granted", $time);
        end
      end
      if (retire_credit_i) returned++;

      // Credits back after a random hold, sometimes a long one
      if (hold_cycles > 0) begin
        hold_cycles--;
        retire_credit_i <= 1'b0;
      end else if (owed > 0) begin
        owed--;
        retire_credit_i <= 1'b1;
        hold_cycles = ($urandom_range(0, 9) == 0) ? $urandom_range(8, 24)
                                                   : $urandom_range(0, 3);
      end else begin
        retire_credit_i <= 1'b0;
      end

      // Issue only while a credit is held
      if (issued < NUM_INSTR && issue_credits > 0 && $urandom_range(0, 9) < 8) begin
        generate_instr(instr);
        issue_instr_i <= instr;
        issue_valid_i <= 1'b1;
        issue_credits--;
        issued++;
      end else begin
        issue_valid_i <= 1'b0;
      end
    end

    // No extra records once the stream is drained
    repeat (10) begin
      @(posedge clk_i);
      issue_valid_i   <= 1'b0;
      retire_credit_i <= 1'b0;
      if (retire_valid_o) begin
        error_count++;
        $display("Extra retire record at %0t after the last instruction", $time);
      end
    end

    check_value("instructions issued", issued, NUM_INSTR);
    check_value("issue_credit_o pulses", credit_pulses, issued);
    check_value("issue credits held", issue_credits, ISSUE_DEPTH);
    check_value("expected records left", exp_q.size(), 0);

    print_summary();
    if (error_count == 0 && DUT.retire_unit_i.props_i.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/rv_core_pkg.sv
hdl/rv_credit_fifo.sv
hdl/rv_register_file.sv
hdl/rv_decode_stage.sv
hdl/rv_execute_stage.sv
hdl/rv_retire_unit.sv
hdl/rv_core_top.sv
verification/rv_core_props.sv
verification/tb_rv_core.sv
